// ==== files.f ====
hw/decode_pkg.sv
hw/rv32i_decoder.sv
hw/register_file.sv
hw/id_ex_register.sv
hw/decode_stage.sv
verif/decode_stage_tb.sv

// ==== hw/decode_pkg.sv ====
package decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CTRL_W     = 12;
    localparam int BR_SEL_W   = 3;
    localparam int ALU_OP_W   = 4;
    localparam int MEM_SIZE_W = 2;

    // Control word bit positions
    localparam int CTRL_REG_WRITE = 0;
    localparam int CTRL_USE_IMM   = 1;
    localparam int CTRL_MEM_READ  = 2;
    localparam int CTRL_MEM_WRITE = 3;
    localparam int CTRL_ALU_OP    = 4;  // Bits 7:4
    localparam int CTRL_JUMP      = 8;
    localparam int CTRL_ILLEGAL   = 9;
    localparam int CTRL_MEM_SIZE  = 10; // Bits 11:10

    // ALU ops, {funct7[5], funct3} for the arithmetic ones
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'b0000;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'b1000;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'b1011; // Unused funct combination

    // Branch select
    localparam logic [BR_SEL_W-1:0] BR_NONE = 3'd0;
    localparam logic [BR_SEL_W-1:0] BR_EQ   = 3'd1;
    localparam logic [BR_SEL_W-1:0] BR_NE   = 3'd2;
    localparam logic [BR_SEL_W-1:0] BR_LT   = 3'd3;
    localparam logic [BR_SEL_W-1:0] BR_GE   = 3'd4;
    localparam logic [BR_SEL_W-1:0] BR_LTU  = 3'd5;
    localparam logic [BR_SEL_W-1:0] BR_GEU  = 3'd6;
    localparam logic [BR_SEL_W-1:0] BR_JUMP = 3'd7;

    //////////////////////////////////////////////////////////////////////
    // RV32I base opcodes
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    // Immediate kinds
    localparam int IMM_KIND_W = 3;
    localparam logic [IMM_KIND_W-1:0] IMM_NONE = 3'd0;
    localparam logic [IMM_KIND_W-1:0] IMM_I    = 3'd1;
    localparam logic [IMM_KIND_W-1:0] IMM_S    = 3'd2;
    localparam logic [IMM_KIND_W-1:0] IMM_B    = 3'd3;
    localparam logic [IMM_KIND_W-1:0] IMM_U    = 3'd4;
    localparam logic [IMM_KIND_W-1:0] IMM_J    = 3'd5;

    // Same word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } rtype;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } stype;
    } instr_u;

endpackage

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              valid_i,
    input  logic [decode_pkg::XLEN-1:0]       instr_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_plus_i,
    input  logic                              branch_pred_i,
    input  logic                              flush_i,
    input  logic                              stall_i,
    input  logic                              wb_we_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [decode_pkg::XLEN-1:0]       wb_data_i,
    output logic                              valid_o,
    output logic                              branch_pred_o,
    output logic [decode_pkg::XLEN-1:0]       data_a_o,
    output logic [decode_pkg::XLEN-1:0]       data_b_o,
    output logic [decode_pkg::XLEN-1:0]       store_data_o,
    output logic [decode_pkg::XLEN-1:0]       pc_plus_o,
    output logic [decode_pkg::CTRL_W-1:0]     ctrl_o,
    output logic [decode_pkg::BR_SEL_W-1:0]   br_sel_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o
);

    logic [decode_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [decode_pkg::XLEN-1:0]       imm;
    logic [decode_pkg::CTRL_W-1:0]     ctrl;
    logic [decode_pkg::BR_SEL_W-1:0]   br_sel;
    logic [decode_pkg::XLEN-1:0]       rs1_data;
    logic [decode_pkg::XLEN-1:0]       rs2_data;

    rv32i_decoder u_decoder (
        .instr_i    (instr_i),
        .rs1_addr_o (rs1_addr_o), // Also out to the hazard unit
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .ctrl_o     (ctrl),
        .br_sel_o   (br_sel)
    );

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .raddr_a_i (rs1_addr_o),
        .raddr_b_i (rs2_addr_o),
        .wdata_i   (wb_data_i),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    id_ex_register u_id_ex_register (
        .clk           (clk),
        .reset         (reset),
        .valid_i       (valid_i),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .branch_pred_i (branch_pred_i),
        .pc_plus_i     (pc_plus_i),
        .imm_i         (imm),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ctrl_i        (ctrl),
        .br_sel_i      (br_sel),
        .rd_addr_i     (rd_addr),
        .valid_o       (valid_o),
        .branch_pred_o (branch_pred_o),
        .pc_plus_o     (pc_plus_o),
        .data_a_o      (data_a_o),
        .data_b_o      (data_b_o),
        .store_data_o  (store_data_o),
        .ctrl_o        (ctrl_o),
        .br_sel_o      (br_sel_o),
        .rd_addr_o     (rd_addr_o)
    );

endmodule

// ==== hw/id_ex_register.sv ====
`timescale 1ns/1ps

module id_ex_register (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              valid_i,
    input  logic                              flush_i,
    input  logic                              stall_i,
    input  logic                              branch_pred_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_plus_i,
    input  logic [decode_pkg::XLEN-1:0]       imm_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [decode_pkg::CTRL_W-1:0]     ctrl_i,
    input  logic [decode_pkg::BR_SEL_W-1:0]   br_sel_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic                              valid_o,
    output logic                              branch_pred_o,
    output logic [decode_pkg::XLEN-1:0]       pc_plus_o,
    output logic [decode_pkg::XLEN-1:0]       data_a_o,
    output logic [decode_pkg::XLEN-1:0]       data_b_o,
    output logic [decode_pkg::XLEN-1:0]       store_data_o,
    output logic [decode_pkg::CTRL_W-1:0]     ctrl_o,
    output logic [decode_pkg::BR_SEL_W-1:0]   br_sel_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_addr_o
);

    logic squash;
    logic [decode_pkg::XLEN-1:0] operand_b;

    assign squash    = flush_i | stall_i | ~valid_i; // Bubble
    assign operand_b = ctrl_i[decode_pkg::CTRL_USE_IMM] ? imm_i : rs2_data_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_o       <= 1'b0;
            branch_pred_o <= 1'b0;
            pc_plus_o     <= '0;
            data_a_o      <= '0;
            data_b_o      <= '0;
            store_data_o  <= '0;
            ctrl_o        <= '0;
            br_sel_o      <= '0;
            rd_addr_o     <= '0;
        end else if (squash) begin
            valid_o       <= 1'b0;
            branch_pred_o <= 1'b0;
            pc_plus_o     <= '0;
            data_a_o      <= '0;
            data_b_o      <= '0;
            store_data_o  <= '0;
            ctrl_o        <= '0; // No write, no memory access
            br_sel_o      <= '0;
            rd_addr_o     <= '0;
        end else begin
            valid_o       <= 1'b1;
            branch_pred_o <= branch_pred_i;
            pc_plus_o     <= pc_plus_i;
            data_a_o      <= rs1_data_i;
            data_b_o      <= operand_b;
            store_data_o  <= rs2_data_i; // Store data is always rs2
            ctrl_o        <= ctrl_i;
            br_sel_o      <= br_sel_i;
            rd_addr_o     <= rd_addr_i;
        end
    end

    no_valid_after_flush_a: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> !valid_o);

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              we_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] raddr_b_i,
    input  logic [decode_pkg::XLEN-1:0]       wdata_i,
    output logic [decode_pkg::XLEN-1:0]       rdata_a_o,
    output logic [decode_pkg::XLEN-1:0]       rdata_b_o
);

    localparam int NUM_REGS = 2 ** decode_pkg::REG_ADDR_W;

    logic [decode_pkg::XLEN-1:0] regs [NUM_REGS];
    logic bypass_a;
    logic bypass_b;

    // x0 never written, so it stays at its reset value
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports with writeback bypass
    //////////////////////////////////////////////////////////////////////

    assign bypass_a = we_i && (waddr_i == raddr_a_i) && (raddr_a_i != '0);
    assign bypass_b = we_i && (waddr_i == raddr_b_i) && (raddr_b_i != '0);

    assign rdata_a_o = bypass_a ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = bypass_b ? wdata_i : regs[raddr_b_i];

    // Holds even with a writeback aimed at x0
    x0_zero_a_a: assert property (@(posedge clk) disable iff (!reset)
        (raddr_a_i == '0) |-> (rdata_a_o == '0));

    x0_zero_b_a: assert property (@(posedge clk) disable iff (!reset)
        (raddr_b_i == '0) |-> (rdata_b_o == '0));

endmodule

// ==== hw/rv32i_decoder.sv ====
`timescale 1ns/1ps

module rv32i_decoder (
    input  logic [decode_pkg::XLEN-1:0]       instr_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic [decode_pkg::XLEN-1:0]       imm_o,
    output logic [decode_pkg::CTRL_W-1:0]     ctrl_o,
    output logic [decode_pkg::BR_SEL_W-1:0]   br_sel_o
);

    decode_pkg::instr_u instr;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [decode_pkg::IMM_KIND_W-1:0] imm_kind;
    logic [decode_pkg::ALU_OP_W-1:0]   alu_op;
    logic use_rs1;
    logic use_rs2;
    logic use_rd;

    logic [decode_pkg::XLEN-1:0] imm_i_fmt;
    logic [decode_pkg::XLEN-1:0] imm_s_fmt;
    logic [decode_pkg::XLEN-1:0] imm_b_fmt;
    logic [decode_pkg::XLEN-1:0] imm_u_fmt;
    logic [decode_pkg::XLEN-1:0] imm_j_fmt;

    assign instr  = instr_i;
    assign opcode = instr.rtype.opcode;
    assign funct3 = instr.rtype.funct3;

    //////////////////////////////////////////////////////////////////////
    // Immediate formats
    //////////////////////////////////////////////////////////////////////

    assign imm_i_fmt = {{20{instr.rtype.funct7[6]}}, instr.rtype.funct7, instr.rtype.rs2};
    assign imm_s_fmt = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_hi, instr.stype.imm_lo};
    assign imm_b_fmt = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_lo[0],
                        instr.stype.imm_hi[5:0], instr.stype.imm_lo[4:1], 1'b0};
    assign imm_u_fmt = {instr.rtype.funct7, instr.rtype.rs2, instr.rtype.rs1,
                        instr.rtype.funct3, 12'b0};
    // J layout scatters bits across rs1, funct3, rs2 and funct7
    assign imm_j_fmt = {{12{instr.rtype.funct7[6]}}, instr.rtype.rs1, instr.rtype.funct3,
                        instr.rtype.rs2[0], instr.rtype.funct7[5:0], instr.rtype.rs2[4:1], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_o   = '0;
        br_sel_o = decode_pkg::BR_NONE;
        imm_kind = decode_pkg::IMM_NONE;
        alu_op   = decode_pkg::ALU_ADD;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        use_rd   = 1'b0;
        case (opcode)
            decode_pkg::OPC_LUI: begin
                imm_kind = decode_pkg::IMM_U;
                alu_op   = decode_pkg::ALU_PASS_B; // rd = imm
                use_rd   = 1'b1;
            end
            decode_pkg::OPC_AUIPC: begin
                imm_kind = decode_pkg::IMM_U;
                use_rd   = 1'b1;
            end
            decode_pkg::OPC_JAL: begin
                imm_kind = decode_pkg::IMM_J;
                br_sel_o = decode_pkg::BR_JUMP;
                use_rd   = 1'b1;
                ctrl_o[decode_pkg::CTRL_JUMP] = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                imm_kind = decode_pkg::IMM_I;
                br_sel_o = decode_pkg::BR_JUMP;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
                ctrl_o[decode_pkg::CTRL_JUMP] = 1'b1;
            end
            decode_pkg::OPC_BRANCH: begin
                imm_kind = decode_pkg::IMM_B;
                alu_op   = decode_pkg::ALU_SUB; // Compare
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                case (funct3)
                    3'b000:  br_sel_o = decode_pkg::BR_EQ;
                    3'b001:  br_sel_o = decode_pkg::BR_NE;
                    3'b100:  br_sel_o = decode_pkg::BR_LT;
                    3'b101:  br_sel_o = decode_pkg::BR_GE;
                    3'b110:  br_sel_o = decode_pkg::BR_LTU;
                    3'b111:  br_sel_o = decode_pkg::BR_GEU;
                    default: br_sel_o = decode_pkg::BR_NONE;
                endcase
            end
            decode_pkg::OPC_LOAD: begin
                imm_kind = decode_pkg::IMM_I;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
                ctrl_o[decode_pkg::CTRL_MEM_READ] = 1'b1;
                ctrl_o[decode_pkg::CTRL_MEM_SIZE +: decode_pkg::MEM_SIZE_W] = funct3[1:0];
            end
            decode_pkg::OPC_STORE: begin
                imm_kind = decode_pkg::IMM_S;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                ctrl_o[decode_pkg::CTRL_MEM_WRITE] = 1'b1;
                ctrl_o[decode_pkg::CTRL_MEM_SIZE +: decode_pkg::MEM_SIZE_W] = funct3[1:0];
            end
            decode_pkg::OPC_OPIMM: begin
                imm_kind = decode_pkg::IMM_I;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
                // funct7[5] only matters for SRAI
                alu_op   = {(funct3 == 3'b101) & instr.rtype.funct7[5], funct3};
            end
            decode_pkg::OPC_OP: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                use_rd   = 1'b1;
                alu_op   = {instr.rtype.funct7[5], funct3};
            end
            default: ctrl_o[decode_pkg::CTRL_ILLEGAL] = 1'b1; // Nothing else set
        endcase
        ctrl_o[decode_pkg::CTRL_REG_WRITE] = use_rd;
        ctrl_o[decode_pkg::CTRL_USE_IMM]   = (imm_kind != decode_pkg::IMM_NONE);
        ctrl_o[decode_pkg::CTRL_ALU_OP +: decode_pkg::ALU_OP_W] = alu_op;
    end

    always_comb begin
        case (imm_kind)
            decode_pkg::IMM_I: imm_o = imm_i_fmt;
            decode_pkg::IMM_S: imm_o = imm_s_fmt;
            decode_pkg::IMM_B: imm_o = imm_b_fmt;
            decode_pkg::IMM_U: imm_o = imm_u_fmt;
            decode_pkg::IMM_J: imm_o = imm_j_fmt;
            default:           imm_o = '0;
        endcase
    end

    // Unused fields read as x0
    assign rs1_addr_o = use_rs1 ? instr.rtype.rs1 : '0;
    assign rs2_addr_o = use_rs2 ? instr.rtype.rs2 : '0;
    assign rd_addr_o  = use_rd  ? instr.rtype.rd  : '0;

    mem_rw_excl_a: assert property (@(instr_i)
        !(ctrl_o[decode_pkg::CTRL_MEM_READ] && ctrl_o[decode_pkg::CTRL_MEM_WRITE]));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module decode_stage_tb \
    -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/decode_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== verif/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int TIMEOUT_CYCLES = 2000; // About ten times the test length

    logic                              clk;
    logic                              reset;
    logic                              valid_i;
    logic [decode_pkg::XLEN-1:0]       instr_i;
    logic [decode_pkg::XLEN-1:0]       pc_plus_i;
    logic                              branch_pred_i;
    logic                              flush_i;
    logic                              stall_i;
    logic                              wb_we_i;
    logic [decode_pkg::REG_ADDR_W-1:0] wb_addr_i;
    logic [decode_pkg::XLEN-1:0]       wb_data_i;
    logic                              valid_o;
    logic                              branch_pred_o;
    logic [decode_pkg::XLEN-1:0]       data_a_o;
    logic [decode_pkg::XLEN-1:0]       data_b_o;
    logic [decode_pkg::XLEN-1:0]       store_data_o;
    logic [decode_pkg::XLEN-1:0]       pc_plus_o;
    logic [decode_pkg::CTRL_W-1:0]     ctrl_o;
    logic [decode_pkg::BR_SEL_W-1:0]   br_sel_o;
    logic [decode_pkg::REG_ADDR_W-1:0] rd_addr_o;
    logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o;

    // Reference model state
    logic [decode_pkg::XLEN-1:0]       shadow [32];
    logic                              exp_valid;
    logic                              exp_branch_pred;
    logic [decode_pkg::XLEN-1:0]       exp_pc_plus;
    logic [decode_pkg::XLEN-1:0]       exp_data_a;
    logic [decode_pkg::XLEN-1:0]       exp_data_b;
    logic [decode_pkg::XLEN-1:0]       exp_store;
    logic [decode_pkg::CTRL_W-1:0]     exp_ctrl;
    logic [decode_pkg::CTRL_W-1:0]     exp_ctrl_mask;
    logic [decode_pkg::BR_SEL_W-1:0]   exp_br_sel;
    logic [decode_pkg::REG_ADDR_W-1:0] exp_rd;
    logic [31:0]                       rng;
    int                                cycle_count = 0;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and instruction rules
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] random_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic is_legal(input logic [6:0] opc);
        return opc inside {decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC, decode_pkg::OPC_JAL,
                           decode_pkg::OPC_JALR, decode_pkg::OPC_BRANCH, decode_pkg::OPC_LOAD,
                           decode_pkg::OPC_STORE, decode_pkg::OPC_OPIMM, decode_pkg::OPC_OP};
    endfunction

    function automatic logic uses_rd(input logic [6:0] opc);
        return opc inside {decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC, decode_pkg::OPC_JAL,
                           decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_OPIMM,
                           decode_pkg::OPC_OP};
    endfunction

    function automatic logic uses_imm(input logic [6:0] opc);
        return is_legal(opc) && (opc != decode_pkg::OPC_OP);
    endfunction

    function automatic logic [4:0] rs1_of(input logic [31:0] w);
        if (w[6:0] inside {decode_pkg::OPC_JALR, decode_pkg::OPC_BRANCH, decode_pkg::OPC_LOAD,
                           decode_pkg::OPC_STORE, decode_pkg::OPC_OPIMM, decode_pkg::OPC_OP})
            return w[19:15];
        return 5'd0; // Format has no rs1
    endfunction

    function automatic logic [4:0] rs2_of(input logic [31:0] w);
        if (w[6:0] inside {decode_pkg::OPC_BRANCH, decode_pkg::OPC_STORE, decode_pkg::OPC_OP})
            return w[24:20];
        return 5'd0;
    endfunction

    // Immediates straight from the RV32I format tables
    function automatic logic [31:0] imm_of(input logic [31:0] w);
        case (w[6:0])
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: return {w[31:12], 12'h000};
            decode_pkg::OPC_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            decode_pkg::OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            decode_pkg::OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_OPIMM:
                return {{20{w[31]}}, w[31:20]};
            default:                return 32'd0;
        endcase
    endfunction

    // Order is none, eq, ne, lt, ge, ltu, geu, jump
    function automatic logic [2:0] br_sel_of(input logic [31:0] w);
        if (w[6:0] == decode_pkg::OPC_JAL || w[6:0] == decode_pkg::OPC_JALR)
            return 3'd7;
        if (w[6:0] != decode_pkg::OPC_BRANCH)
            return 3'd0;
        case (w[14:12])
            3'b000:  return 3'd1;
            3'b001:  return 3'd2;
            3'b100:  return 3'd3;
            3'b101:  return 3'd4;
            3'b110:  return 3'd5;
            3'b111:  return 3'd6;
            default: return 3'd0;
        endcase
    endfunction

    function automatic logic [decode_pkg::CTRL_W-1:0] ctrl_bits_of(input logic [31:0] w);
        logic [decode_pkg::CTRL_W-1:0] c;
        logic [6:0] opc;
        opc = w[6:0];
        c   = '0;
        if (!is_legal(opc)) begin
            c[decode_pkg::CTRL_ILLEGAL] = 1'b1;
            return c;
        end
        c[decode_pkg::CTRL_REG_WRITE] = uses_rd(opc);
        c[decode_pkg::CTRL_USE_IMM]   = uses_imm(opc);
        c[decode_pkg::CTRL_MEM_READ]  = (opc == decode_pkg::OPC_LOAD);
        c[decode_pkg::CTRL_MEM_WRITE] = (opc == decode_pkg::OPC_STORE);
        c[decode_pkg::CTRL_JUMP]      = (opc == decode_pkg::OPC_JAL) ||
                                        (opc == decode_pkg::OPC_JALR);
        if (opc == decode_pkg::OPC_LOAD || opc == decode_pkg::OPC_STORE)
            c[decode_pkg::CTRL_MEM_SIZE +: 2] = w[13:12];
        return c;
    endfunction

    function automatic logic [decode_pkg::CTRL_W-1:0] ctrl_mask_of(input logic [31:0] w);
        logic [decode_pkg::CTRL_W-1:0] m;
        m = '1;
        if (is_legal(w[6:0])) begin
            m[decode_pkg::CTRL_ALU_OP +: 4] = 4'd0; // ALU op encoding left to execute
            if (w[6:0] != decode_pkg::OPC_LOAD && w[6:0] != decode_pkg::OPC_STORE)
                m[decode_pkg::CTRL_MEM_SIZE +: 2] = 2'd0;
        end
        return m;
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        if (a == 5'd0)
            return 32'd0;
        if (wb_we_i && wb_addr_i == a)
            return wb_data_i; // Same-cycle writeback
        return shadow[a];
    endfunction

    function automatic logic [31:0] random_instr(input logic [6:0] opc);
        logic [31:0] w;
        w      = random_word();
        w[6:0] = opc;
        if (opc == decode_pkg::OPC_OP)
            w[31:25] = {1'b0, w[30], 5'b0};
        if (opc == decode_pkg::OPC_BRANCH && w[14:13] == 2'b01)
            w[13] = 1'b0; // Skip the two unused funct3 codes
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, one cycle behind the inputs
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= 32'd0;
            end
        end else if (wb_we_i && wb_addr_i != 5'd0) begin
            shadow[wb_addr_i] <= wb_data_i;
        end
    end

    always @(posedge clk or negedge reset) begin
        if (!reset || !valid_i || flush_i || stall_i) begin
            exp_valid       <= 1'b0;  // Bubble
            exp_branch_pred <= 1'b0;
            exp_pc_plus     <= '0;
            exp_data_a      <= '0;
            exp_data_b      <= '0;
            exp_store       <= '0;
            exp_ctrl        <= '0;
            exp_ctrl_mask   <= '1;
            exp_br_sel      <= '0;
            exp_rd          <= '0;
        end else begin
            exp_valid       <= 1'b1;
            exp_branch_pred <= branch_pred_i;
            exp_pc_plus     <= pc_plus_i;
            exp_data_a      <= reg_value(rs1_of(instr_i));
            exp_data_b      <= uses_imm(instr_i[6:0]) ? imm_of(instr_i)
                                                      : reg_value(rs2_of(instr_i));
            exp_store       <= reg_value(rs2_of(instr_i));
            exp_ctrl        <= ctrl_bits_of(instr_i);
            exp_ctrl_mask   <= ctrl_mask_of(instr_i);
            exp_br_sel      <= br_sel_of(instr_i);
            exp_rd          <= uses_rd(instr_i[6:0]) ? instr_i[11:7] : 5'd0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    valid_chk: assert property (@(posedge clk) disable iff (!reset) valid_o == exp_valid)
        else report_mismatch("valid", 32'($sampled(exp_valid)), 32'($sampled(valid_o)));

    ctrl_chk: assert property (@(posedge clk) disable iff (!reset)
        (ctrl_o & exp_ctrl_mask) == exp_ctrl)
        else report_mismatch("ctrl", 32'($sampled(exp_ctrl)),
                             32'($sampled(ctrl_o & exp_ctrl_mask)));

    br_sel_chk: assert property (@(posedge clk) disable iff (!reset) br_sel_o == exp_br_sel)
        else report_mismatch("br_sel", 32'($sampled(exp_br_sel)), 32'($sampled(br_sel_o)));

    data_a_chk: assert property (@(posedge clk) disable iff (!reset) data_a_o == exp_data_a)
        else report_mismatch("data_a", $sampled(exp_data_a), $sampled(data_a_o));

    data_b_chk: assert property (@(posedge clk) disable iff (!reset) data_b_o == exp_data_b)
        else report_mismatch("data_b", $sampled(exp_data_b), $sampled(data_b_o));

    store_chk: assert property (@(posedge clk) disable iff (!reset) store_data_o == exp_store)
        else report_mismatch("store_data", $sampled(exp_store), $sampled(store_data_o));

    pc_plus_chk: assert property (@(posedge clk) disable iff (!reset) pc_plus_o == exp_pc_plus)
        else report_mismatch("pc_plus", $sampled(exp_pc_plus), $sampled(pc_plus_o));

    branch_pred_chk: assert property (@(posedge clk) disable iff (!reset)
        branch_pred_o == exp_branch_pred)
        else report_mismatch("branch_pred", 32'($sampled(exp_branch_pred)),
                             32'($sampled(branch_pred_o)));

    rd_chk: assert property (@(posedge clk) disable iff (!reset) rd_addr_o == exp_rd)
        else report_mismatch("rd_addr", 32'($sampled(exp_rd)), 32'($sampled(rd_addr_o)));

    // Hazard-unit addresses are combinational from the current word
    rs_addr_chk: assert property (@(posedge clk) disable iff (!reset)
        rs1_addr_o == rs1_of(instr_i) && rs2_addr_o == rs2_of(instr_i))
        else report_mismatch("rs_addr",
                             32'({rs1_of($sampled(instr_i)), rs2_of($sampled(instr_i))}),
                             32'({$sampled(rs1_addr_o), $sampled(rs2_addr_o)}));

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive(input logic v, input logic [31:0] w, input logic fl, input logic st,
                         input logic we, input logic [4:0] wa, input logic [31:0] wd);
        logic [31:0] r;
        r = random_word();
        @(posedge clk);
        valid_i       <= v;
        instr_i       <= w;
        pc_plus_i     <= {r[31:2], 2'b00};
        branch_pred_i <= r[0];
        flush_i       <= fl;
        stall_i       <= st;
        wb_we_i       <= we;
        wb_addr_i     <= wa;
        wb_data_i     <= wd;
    endtask

    task automatic send(input logic v, input logic [31:0] w, input logic fl, input logic st);
        logic [31:0] r;
        r = random_word();
        drive(v, w, fl, st, r[0], r[5:1], random_word()); // Random writeback alongside
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        rng           = 32'd16123;
        reset         <= 1'b0;
        valid_i       <= 1'b0;
        instr_i       <= decode_pkg::NOP_INSTR;
        pc_plus_i     <= '0;
        branch_pred_i <= 1'b0;
        flush_i       <= 1'b0;
        stall_i       <= 1'b0;
        wb_we_i       <= 1'b0;
        wb_addr_i     <= '0;
        wb_data_i     <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        repeat (3) drive(1'b0, decode_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        for (int i = 0; i < 32; i++) begin
            drive(1'b0, decode_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b1, 5'(i), random_word());
        end
        repeat (30) send(1'b1, random_instr(decode_pkg::OPC_OP), 1'b0, 1'b0);
        repeat (10) begin
            w        = random_instr(decode_pkg::OPC_OP);
            w[15]    = 1'b1; // Nonzero rs1 so the bypass applies
            drive(1'b1, w, 1'b0, 1'b0, 1'b1, w[19:15], random_word());
        end
        repeat (20) begin
            send(1'b1, random_instr(decode_pkg::OPC_OPIMM), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_LOAD), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_STORE), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_BRANCH), 1'b0, 1'b0);
        end
        repeat (5) begin
            send(1'b1, random_instr(decode_pkg::OPC_LUI), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_AUIPC), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_JAL), 1'b0, 1'b0);
            send(1'b1, random_instr(decode_pkg::OPC_JALR), 1'b0, 1'b0);
        end
        send(1'b1, decode_pkg::NOP_INSTR, 1'b0, 1'b0);
        repeat (10) begin
            r = random_word();
            send(1'b1, random_instr(decode_pkg::OPC_OP), r[0], ~r[0] | r[1]);
            send(1'b0, random_instr(decode_pkg::OPC_LOAD), 1'b0, 1'b0);
        end
        send(1'b1, 32'h0000_0000, 1'b0, 1'b0);
        send(1'b1, 32'hFFFF_FFFF, 1'b0, 1'b0);
        send(1'b1, 32'h0000_000F, 1'b0, 1'b0); // FENCE is outside the decoded set
        send(1'b1, random_instr(7'b1010011), 1'b0, 1'b0);
        // Last word registers one edge later and is compared on the edge after
        repeat (3) drive(1'b0, decode_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
